/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for a pass"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pid_controller \
		-f flist.f -Mdir obj_dir -o sim_pid
	./obj_dir/sim_pid | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
src/pid_pkg.sv
src/pid_cfg_if.sv
src/pid_regs.sv
src/pid_pipeline.sv
src/pid_out_queue.sv
src/pid_controller.sv
verification/tb_pid_controller.sv

/* src/pid_cfg_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface pid_cfg_if (
    input logic wr_en
);
    import pid_pkg::*;

    // Channel select comes from the pipeline, the rest answers it
    logic [CHAN_W-1:0]        cfg_chan;
    logic signed [DATA_W-1:0] setpoint;
    logic signed [COEF_W-1:0] kp;
    logic signed [COEF_W-1:0] ki;
    logic signed [COEF_W-1:0] kd;
    logic [N_CHAN-1:0]        enable;
    logic                     clr_integ;

    modport regs (
        input  cfg_chan,
        output setpoint, kp, ki, kd, enable, clr_integ
    );

    modport pipe (
        output cfg_chan,
        input  setpoint, kp, ki, kd, enable, clr_integ
    );

endinterface

`default_nettype wire

/* src/pid_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module pid_controller (
    input  logic                               wr_en,
    input  logic                               arst_n,
    // AXI4-Lite host port
    input  logic [pid_pkg::AXI_ADDR_W-1:0]     s_axi_awaddr,
    input  logic                               s_axi_awvalid,
    output logic                               s_axi_awready,
    input  logic [pid_pkg::AXI_DATA_W-1:0]     s_axi_wdata,
    input  logic [pid_pkg::AXI_DATA_W/8-1:0]   s_axi_wstrb,
    input  logic                               s_axi_wvalid,
    output logic                               s_axi_wready,
    output logic [1:0]                         s_axi_bresp,
    output logic                               s_axi_bvalid,
    input  logic                               s_axi_bready,
    input  logic [pid_pkg::AXI_ADDR_W-1:0]     s_axi_araddr,
    input  logic                               s_axi_arvalid,
    output logic                               s_axi_arready,
    output logic [pid_pkg::AXI_DATA_W-1:0]     s_axi_rdata,
    output logic [1:0]                         s_axi_rresp,
    output logic                               s_axi_rvalid,
    input  logic                               s_axi_rready,
    // Sample and result streams
    input  logic                               sample_valid,
    output logic                               sample_ready,
    input  logic [pid_pkg::CHAN_W-1:0]         sample_chan,
    input  logic signed [pid_pkg::DATA_W-1:0]  sample_data,
    output logic                               result_valid,
    input  logic                               result_ready,
    output logic [pid_pkg::CHAN_W-1:0]         result_chan,
    output logic signed [pid_pkg::DATA_W-1:0]  result_data
);
    import pid_pkg::*;

    logic                     pipe_valid;
    logic [CHAN_W-1:0]        pipe_chan;
    logic signed [DATA_W-1:0] pipe_data;
    logic [1:0]               pipe_busy;

    pid_cfg_if i_cfg (.wr_en(wr_en));

    // ------------------------------------------------------------
    // Register block beside the pipeline
    // ------------------------------------------------------------
    pid_regs i_regs (
        .wr_en         (wr_en),
        .arst_n        (arst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .cfg           (i_cfg.regs)
    );

    pid_pipeline i_pipeline (
        .wr_en        (wr_en),
        .arst_n       (arst_n),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .sample_chan  (sample_chan),
        .sample_data  (sample_data),
        .out_valid    (pipe_valid),
        .out_chan     (pipe_chan),
        .out_data     (pipe_data),
        .busy         (pipe_busy),
        .cfg          (i_cfg.pipe)
    );

    pid_out_queue i_queue (
        .wr_en        (wr_en),
        .arst_n       (arst_n),
        .push_valid   (pipe_valid),
        .push_chan    (pipe_chan),
        .push_data    (pipe_data),
        .pipe_busy    (pipe_busy),
        .sample_ready (sample_ready),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_chan  (result_chan),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

/* src/pid_out_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module pid_out_queue (
    input  logic                               wr_en,
    input  logic                               arst_n,
    input  logic                               push_valid,
    input  logic [pid_pkg::CHAN_W-1:0]         push_chan,
    input  logic signed [pid_pkg::DATA_W-1:0]  push_data,
    input  logic [1:0]                         pipe_busy,
    output logic                               sample_ready,
    output logic                               result_valid,
    input  logic                               result_ready,
    output logic [pid_pkg::CHAN_W-1:0]         result_chan,
    output logic signed [pid_pkg::DATA_W-1:0]  result_data
);
    import pid_pkg::*;

    logic [CHAN_W-1:0]        mem_chan [4];
    logic signed [DATA_W-1:0] mem_data [4];
    logic [1:0]               wr_ptr;
    logic [1:0]               rd_ptr;
    logic [2:0]               count;
    logic [2:0]               occupied;
    logic                     pop;
    logic                     ready_en;

    assign pop = result_valid && result_ready;

    // Slots promised to results still in the pipeline count as used
    assign occupied     = count - {2'b0, pop} + {1'b0, pipe_busy};
    assign sample_ready = ready_en && (occupied < 3'd4);

    // Show-ahead head of the queue
    assign result_chan = mem_chan[rd_ptr];
    assign result_data = mem_data[rd_ptr];

    always_ff @(posedge wr_en) begin
        if (push_valid) begin
            mem_chan[wr_ptr] <= push_chan;
            mem_data[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge wr_en or negedge arst_n) begin
        if (!arst_n) begin
            ready_en     <= 1'b0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            result_valid <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (push_valid) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            count <= count + {2'b0, push_valid} - {2'b0, pop};
            // A fresh entry shows one cycle after its write
            result_valid <= (count - {2'b0, pop}) != 3'd0;
        end
    end

    assert property (@(posedge wr_en) disable iff (!arst_n) push_valid |-> count != 3'd4);

endmodule

`default_nettype wire

/* src/pid_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

module pid_pipeline (
    input  logic                               wr_en,
    input  logic                               arst_n,
    input  logic                               sample_valid,
    input  logic                               sample_ready,
    input  logic [pid_pkg::CHAN_W-1:0]         sample_chan,
    input  logic signed [pid_pkg::DATA_W-1:0]  sample_data,
    output logic                               out_valid,
    output logic [pid_pkg::CHAN_W-1:0]         out_chan,
    output logic signed [pid_pkg::DATA_W-1:0]  out_data,
    output logic [1:0]                         busy,
    pid_cfg_if.pipe                            cfg
);
    import pid_pkg::*;

    logic                      accept;
    logic                      s1_valid;
    logic                      s1_en;
    logic [CHAN_W-1:0]         s1_chan;
    logic signed [DATA_W:0]    s1_err;
    logic signed [COEF_W-1:0]  s1_kp;
    logic signed [COEF_W-1:0]  s1_ki;
    logic signed [COEF_W-1:0]  s1_kd;
    logic                      s2_valid;
    logic                      s2_en;
    logic [CHAN_W-1:0]         s2_chan;
    logic signed [ACC_W-1:0]   s2_pp;
    logic signed [ACC_W-1:0]   s2_pi;
    logic signed [ACC_W-1:0]   s2_pd;

    // Per-channel state
    logic signed [INTEG_W-1:0] integ_mem [N_CHAN];
    logic signed [DATA_W:0]    eprev_mem [N_CHAN];

    logic signed [INTEG_W:0]   integ_sum;
    logic signed [INTEG_W-1:0] integ_new;
    logic signed [DATA_W+1:0]  d_err;
    logic signed [ACC_W-1:0]   acc_sum;
    logic signed [ACC_W-1:0]   acc_shr;
    logic signed [DATA_W-1:0]  sat_data;

    assign accept       = sample_valid && sample_ready;
    assign cfg.cfg_chan = sample_chan;
    assign busy         = {1'b0, s1_valid} + {1'b0, s2_valid} + {1'b0, out_valid};

    always_ff @(posedge wr_en or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= accept;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    // ------------------------------------------------------------
    // Stage 2 and 3 arithmetic
    // ------------------------------------------------------------
    always_comb begin
        integ_sum = (INTEG_W+1)'(integ_mem[s1_chan]) + (INTEG_W+1)'(s1_err);
        if (integ_sum[INTEG_W] != integ_sum[INTEG_W-1]) begin
            integ_new = {integ_sum[INTEG_W], {(INTEG_W-1){~integ_sum[INTEG_W]}}};
        end else begin
            integ_new = integ_sum[INTEG_W-1:0];
        end
        d_err = (DATA_W+2)'(s1_err) - (DATA_W+2)'(eprev_mem[s1_chan]);

        acc_sum = s2_pp + s2_pi + s2_pd;
        acc_shr = acc_sum >>> COEF_FRAC;
        // Upper bits all equal to the sign means it fits
        if (&acc_shr[ACC_W-1:DATA_W-1] || !(|acc_shr[ACC_W-1:DATA_W-1])) begin
            sat_data = acc_shr[DATA_W-1:0];
        end else begin
            sat_data = {acc_shr[ACC_W-1], {(DATA_W-1){~acc_shr[ACC_W-1]}}};
        end
    end

    always_ff @(posedge wr_en) begin
        // Stage 1 latches coefficients and the error
        s1_chan <= sample_chan;
        s1_en   <= cfg.enable[sample_chan];
        s1_err  <= (DATA_W+1)'(cfg.setpoint) - (DATA_W+1)'(sample_data);
        s1_kp   <= cfg.kp;
        s1_ki   <= cfg.ki;
        s1_kd   <= cfg.kd;
        // Stage 2 products
        s2_chan <= s1_chan;
        s2_en   <= s1_en;
        s2_pp   <= ACC_W'(s1_kp) * ACC_W'(s1_err);
        s2_pi   <= ACC_W'(s1_ki) * ACC_W'(integ_new);
        s2_pd   <= ACC_W'(s1_kd) * ACC_W'(d_err);
        // Stage 3 result, zero for a disabled channel
        out_chan <= s2_chan;
        out_data <= s2_en ? sat_data : '0;
    end

    // State is written on the stage-2 edge, so a following sample of the
    // same channel reads the fresh integrator and previous error
    always_ff @(posedge wr_en or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_CHAN; i++) begin
                integ_mem[i] <= '0;
                eprev_mem[i] <= '0;
            end
        end else if (cfg.clr_integ) begin
            for (int i = 0; i < N_CHAN; i++) begin
                integ_mem[i] <= '0;
                eprev_mem[i] <= '0;
            end
        end else if (s1_valid && s1_en) begin
            integ_mem[s1_chan] <= integ_new;
            eprev_mem[s1_chan] <= s1_err;
        end
    end

    // Clear wins over a stage-2 update of the same edge
    assert property (@(posedge wr_en) disable iff (!arst_n)
        cfg.clr_integ && s1_valid |=>
            integ_mem[$past(s1_chan)] == '0 && eprev_mem[$past(s1_chan)] == '0);

endmodule

`default_nettype wire

/* src/pid_pkg.sv */
`default_nettype none

package pid_pkg;

    // ------------------------------------------------------------
    // Datapath sizes
    // ------------------------------------------------------------
    localparam int N_CHAN    = 4;
    localparam int CHAN_W    = 2;
    localparam int DATA_W    = 16;
    // Gains are Q8.8
    localparam int COEF_W    = 16;
    localparam int COEF_FRAC = 8;
    localparam int INTEG_W   = 24;
    localparam int ACC_W     = 48;

    // ------------------------------------------------------------
    // AXI4-Lite register map
    // ------------------------------------------------------------
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;

    // Offsets inside one channel block
    localparam logic [AXI_ADDR_W-1:0] REG_SETPOINT = 8'h00;
    localparam logic [AXI_ADDR_W-1:0] REG_KP       = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_KI       = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_KD       = 8'h0C;
    localparam logic [AXI_ADDR_W-1:0] CHAN_STRIDE  = 8'h10;
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL     = 8'h40;

    // CTRL bits 3..0 enable the channels
    localparam int CTRL_CLR_BIT = 8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* src/pid_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module pid_regs (
    input  logic                              wr_en,
    input  logic                              arst_n,
    input  logic [pid_pkg::AXI_ADDR_W-1:0]    s_axi_awaddr,
    input  logic                              s_axi_awvalid,
    output logic                              s_axi_awready,
    input  logic [pid_pkg::AXI_DATA_W-1:0]    s_axi_wdata,
    input  logic [pid_pkg::AXI_DATA_W/8-1:0]  s_axi_wstrb,
    input  logic                              s_axi_wvalid,
    output logic                              s_axi_wready,
    output logic [1:0]                        s_axi_bresp,
    output logic                              s_axi_bvalid,
    input  logic                              s_axi_bready,
    input  logic [pid_pkg::AXI_ADDR_W-1:0]    s_axi_araddr,
    input  logic                              s_axi_arvalid,
    output logic                              s_axi_arready,
    output logic [pid_pkg::AXI_DATA_W-1:0]    s_axi_rdata,
    output logic [1:0]                        s_axi_rresp,
    output logic                              s_axi_rvalid,
    input  logic                              s_axi_rready,
    pid_cfg_if.regs                           cfg
);
    import pid_pkg::*;

    // Four words per channel block, indexed {chan, word}
    logic [COEF_W-1:0] regfile [4*N_CHAN];
    logic [N_CHAN-1:0] enable_q;
    logic              clr_q;
    logic [5:0]        wsel;
    logic [5:0]        rsel;
    logic [COEF_W-1:0] wmerge;
    logic [COEF_W-1:0] rword;

    // Result is {hit, ctrl, index}
    function automatic logic [5:0] decode(input logic [AXI_ADDR_W-1:0] addr);
        logic [5:0] sel;
        sel = '0;
        if (addr == REG_CTRL) begin
            sel = 6'b110000;
        end else if (addr < N_CHAN * CHAN_STRIDE && addr[1:0] == 2'b00) begin
            sel = {2'b10, 4'((addr / CHAN_STRIDE) * 4 + (addr % CHAN_STRIDE) / 4)};
        end
        return sel;
    endfunction

    assign wsel = decode(s_axi_awaddr);
    assign rsel = decode(s_axi_araddr);

    // Byte lanes not strobed keep their old contents
    assign wmerge = {s_axi_wstrb[1] ? s_axi_wdata[15:8] : regfile[wsel[3:0]][15:8],
                     s_axi_wstrb[0] ? s_axi_wdata[7:0]  : regfile[wsel[3:0]][7:0]};

    assign rword = rsel[4] ? COEF_W'(enable_q) : regfile[rsel[3:0]];

    // ------------------------------------------------------------
    // Write and read channels
    // ------------------------------------------------------------
    always_ff @(posedge wr_en or negedge arst_n) begin
        if (!arst_n) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_bresp   <= RESP_OKAY;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rresp   <= RESP_OKAY;
            s_axi_rdata   <= '0;
            enable_q      <= '0;
            clr_q         <= 1'b0;
            for (int i = 0; i < 4 * N_CHAN; i++) begin
                regfile[i] <= '0;
            end
        end else begin
            clr_q         <= 1'b0;
            s_axi_awready <= s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
            s_axi_wready  <= s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
            s_axi_arready <= s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;

            if (s_axi_awready) begin
                s_axi_bvalid <= 1'b1;
                s_axi_bresp  <= wsel[5] ? RESP_OKAY : RESP_SLVERR;
                if (wsel[5] && wsel[4]) begin
                    if (s_axi_wstrb[0]) begin
                        enable_q <= s_axi_wdata[N_CHAN-1:0];
                    end
                    clr_q <= s_axi_wstrb[1] && s_axi_wdata[CTRL_CLR_BIT];
                end else if (wsel[5]) begin
                    regfile[wsel[3:0]] <= wmerge;
                end
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end

            if (s_axi_arready) begin
                s_axi_rvalid <= 1'b1;
                s_axi_rresp  <= rsel[5] ? RESP_OKAY : RESP_SLVERR;
                s_axi_rdata  <= rsel[5] ? AXI_DATA_W'(rword) : '0;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    // Coefficients of the channel the pipeline is looking at
    assign cfg.setpoint  = regfile[{cfg.cfg_chan, 2'(REG_SETPOINT / 4)}];
    assign cfg.kp        = regfile[{cfg.cfg_chan, 2'(REG_KP / 4)}];
    assign cfg.ki        = regfile[{cfg.cfg_chan, 2'(REG_KI / 4)}];
    assign cfg.kd        = regfile[{cfg.cfg_chan, 2'(REG_KD / 4)}];
    assign cfg.enable    = enable_q;
    assign cfg.clr_integ = clr_q;

    // Responses stay put until the host takes them
    assert property (@(posedge wr_en) disable iff (!arst_n)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));
    assert property (@(posedge wr_en) disable iff (!arst_n)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

`default_nettype wire

/* verification/pid_patterns.txt */
// op addr/chan aux data. op 1 write (aux resp,strb) 2 read (aux resp) 3 sample 4 result
// 5 ready mode (0 random 1 low 2 high) 6 idle data cycles, sample_ready = aux 7 latency 8 test end
1 00 03 00000100
1 04 03 00000200
2 00 00 00000100
1 04 01 0000AB55 // low byte only
2 04 00 00000255
1 40 0F 0000000F
2 40 00 0000000F
1 44 2F 12345678
2 44 02 00000000
1 02 23 00000001 // misaligned
8 00 00 00000001
1 10 03 00000100
1 14 03 00000200
1 24 03 00000080
3 01 00 00000080
3 01 00 00000180
3 02 00 0000FF00
3 02 00 00000003
4 01 00 00000100
4 01 00 0000FF00
4 02 00 00000080
4 02 00 0000FFFE
8 00 00 00000002
1 30 03 00000040
1 34 03 00000100
1 38 03 00000080
1 3C 03 00000200
3 03 00 00000000
3 03 00 00000020
3 03 00 00000050
4 03 00 000000E0
4 03 00 00000010
4 03 00 0000FFB8
1 40 03 0000010F // clear integrators
2 40 00 0000000F
3 03 00 00000000
4 03 00 000000E0
8 00 00 00000003
1 00 03 00000000
1 04 03 00007FFF
1 18 03 00000100
1 40 01 0000000B // channel 2 off
3 00 00 00008000
3 00 00 00007FFF
3 02 00 00000000
3 03 00 00000040
3 01 00 00000000
3 03 00 00000040
3 01 00 00000100
4 00 00 00007FFF
4 00 00 00008000
4 02 00 00000000
4 03 00 0000FFA0
4 01 00 00000300
4 03 00 00000020
4 01 00 00000100
8 00 00 00000004
5 00 01 00000000
3 01 00 00000180
3 01 00 000000C0
3 01 00 00000100
3 01 00 00000140
6 00 00 00000006
5 00 00 00000000
4 01 00 0000FF80
4 01 00 00000140
4 01 00 000000C0
4 01 00 00000000
5 00 02 00000000
7 03 04 00000040
4 03 00 00000020
8 00 00 00000005
0 00 00 00000000

/* verification/tb_pid_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pid_controller;
    import pid_pkg::*;

    localparam int MAX_OPS   = 128;
    localparam int LFSR_SEED = 80263;

    logic                     wr_en;
    logic                     arst_n;
    logic [AXI_ADDR_W-1:0]    s_axi_awaddr;
    logic                     s_axi_awvalid;
    logic                     s_axi_awready;
    logic [AXI_DATA_W-1:0]    s_axi_wdata;
    logic [AXI_DATA_W/8-1:0]  s_axi_wstrb;
    logic                     s_axi_wvalid;
    logic                     s_axi_wready;
    logic [1:0]               s_axi_bresp;
    logic                     s_axi_bvalid;
    logic                     s_axi_bready;
    logic [AXI_ADDR_W-1:0]    s_axi_araddr;
    logic                     s_axi_arvalid;
    logic                     s_axi_arready;
    logic [AXI_DATA_W-1:0]    s_axi_rdata;
    logic [1:0]               s_axi_rresp;
    logic                     s_axi_rvalid;
    logic                     s_axi_rready;
    logic                     sample_valid;
    logic                     sample_ready;
    logic [CHAN_W-1:0]        sample_chan;
    logic signed [DATA_W-1:0] sample_data;
    logic                     result_valid;
    logic                     result_ready;
    logic [CHAN_W-1:0]        result_chan;
    logic signed [DATA_W-1:0] result_data;

    // Four words per pattern line: op, address or channel, aux, data
    logic [31:0]       pattern [4*MAX_OPS];
    int                n_ops = 0;
    int                checks = 0;
    int                errors = 0;
    int                edges = 0;
    int                ready_mode = 0;
    logic [16:0]       lfsr;
    logic [CHAN_W-1:0] got_chan [$];
    logic [DATA_W-1:0] got_data [$];

    pid_controller i_pid_controller (.*);

    initial begin
        wr_en = 1'b0;
        forever begin
            #2 wr_en = ~wr_en;
        end
    end

    always @(posedge wr_en) edges <= edges + 1;

    // x^17 + x^14 + 1, maximal length
    function automatic logic [16:0] lfsr_step(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // Called right after a falling edge; looks at what the next rising edge will see
    task automatic settle();
        case (ready_mode)
            1: result_ready = 1'b0;
            2: result_ready = 1'b1;
            default: begin
                lfsr = lfsr_step(lfsr);
                result_ready = lfsr[0];
            end
        endcase
        #1;
        if (result_valid && result_ready) begin
            got_chan.push_back(result_chan);
            got_data.push_back(result_data);
        end
    endtask

    task automatic idle_cycle();
        @(negedge wr_en);
        sample_valid = 1'b0;
        settle();
    endtask

    task automatic send_sample(input logic [CHAN_W-1:0] chan, input logic [DATA_W-1:0] data);
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge wr_en);
            sample_valid = 1'b1;
            sample_chan  = chan;
            sample_data  = data;
            settle();
            accepted = sample_ready;
        end
    endtask

    // Address and data stay put until the response arrives
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        bit done;
        @(negedge wr_en);
        sample_valid  = 1'b0;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        settle();
        done = 1'b0;
        while (!done) begin
            @(negedge wr_en);
            if (s_axi_awready) begin
                // Both ready lines pulse in the same cycle
                check("s_axi_wready", 32'(s_axi_wready), 32'd1);
                s_axi_awvalid = 1'b0;
                s_axi_wvalid  = 1'b0;
                done = 1'b1;
            end
            settle();
        end
        done = 1'b0;
        while (!done) begin
            @(negedge wr_en);
            if (s_axi_bvalid) begin
                resp = s_axi_bresp;
                done = 1'b1;
            end
            settle();
        end
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        bit done;
        @(negedge wr_en);
        sample_valid  = 1'b0;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        settle();
        done = 1'b0;
        while (!done) begin
            @(negedge wr_en);
            if (s_axi_arready) begin
                s_axi_arvalid = 1'b0;
                done = 1'b1;
            end
            settle();
        end
        done = 1'b0;
        while (!done) begin
            @(negedge wr_en);
            if (s_axi_rvalid) begin
                data = s_axi_rdata;
                resp = s_axi_rresp;
                done = 1'b1;
            end
            settle();
        end
    endtask

    // ------------------------------------------------------------
    // Pattern interpreter
    // ------------------------------------------------------------
    initial begin
        int                i;
        int                test_errors;
        int                acc_edge;
        logic [3:0]        op;
        logic [7:0]        arg;
        logic [7:0]        aux;
        logic [31:0]       data;
        logic [31:0]       rdata;
        logic [1:0]        resp;
        logic [CHAN_W-1:0] gchan;
        logic [DATA_W-1:0] gdata;

        arst_n        = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        sample_valid  = 1'b0;
        sample_chan   = '0;
        sample_data   = '0;
        result_ready  = 1'b0;
        lfsr          = 17'(LFSR_SEED);
        test_errors   = 0;

        for (i = 0; i < 4 * MAX_OPS; i++) begin
            pattern[i] = '0;
        end
        $readmemh("verification/pid_patterns.txt", pattern);
        while (n_ops < MAX_OPS && pattern[4*n_ops][3:0] != 4'd0) begin
            n_ops++;
        end

        repeat (4) @(posedge wr_en);
        @(negedge wr_en);
        arst_n = 1'b1;

        for (i = 0; i < n_ops; i++) begin
            op   = pattern[4*i][3:0];
            arg  = pattern[4*i+1][7:0];
            aux  = pattern[4*i+2][7:0];
            data = pattern[4*i+3];
            // A held sample must drop before anything else happens
            if (op != 4'd3 && sample_valid) begin
                idle_cycle();
            end
            case (op)
                4'd1: begin
                    axi_write(arg, data, aux[3:0], resp);
                    check("s_axi_bresp", 32'(resp), 32'(aux[7:4]));
                end
                4'd2: begin
                    axi_read(arg, rdata, resp);
                    check("s_axi_rresp", 32'(resp), 32'(aux));
                    check("s_axi_rdata", rdata, data);
                end
                4'd3: send_sample(arg[CHAN_W-1:0], data[DATA_W-1:0]);
                4'd4: begin
                    while (got_data.size() == 0) begin
                        idle_cycle();
                    end
                    gchan = got_chan.pop_front();
                    gdata = got_data.pop_front();
                    check("result_chan", 32'(gchan), 32'(arg[CHAN_W-1:0]));
                    check("result_data", 32'(gdata), data);
                end
                4'd5: ready_mode = int'(aux);
                4'd6: begin
                    repeat (data) idle_cycle();
                    check("sample_ready", 32'(sample_ready), 32'(aux));
                end
                4'd7: begin
                    send_sample(arg[CHAN_W-1:0], data[DATA_W-1:0]);
                    acc_edge = edges + 1;
                    while (!result_valid) begin
                        idle_cycle();
                    end
                    check("result_valid latency", 32'(edges - acc_edge), 32'(aux));
                end
                4'd8: begin
                    $display("Test %0d finished with %0d errors", data, errors - test_errors);
                    test_errors = errors;
                end
                default: begin
                    $display("Pattern line %0d has an unknown operation %0d", i, op);
                    errors++;
                end
            endcase
        end

        if (n_ops == 0) begin
            $display("No operations were read from the pattern file");
            errors++;
        end
        if (got_data.size() != 0) begin
            $display("%0d results arrived that no pattern line expected", got_data.size());
            errors++;
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Forty cycles per pattern line is far more than any operation needs
    initial begin
        wait (arst_n === 1'b1 && n_ops != 0);
        repeat (n_ops * 40) @(posedge wr_en);
        $display("Timeout: the run did not finish within %0d cycles", n_ops * 40);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
